// File: mc_consts.svh
//*********************************************************************
// pod sizing, host address fields, fifo depth and core reset depth
//*********************************************************************
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

`define MC_NUM_TILES    4
`define MC_DMEM_WORDS   64
`define MC_DATA_W       32
`define MC_ADDR_W       16

// host word address layout
`define MC_REGION_MSB   15
`define MC_REGION_LSB   14
`define MC_TILE_MSB     13
`define MC_TILE_LSB     12
`define MC_WORD_MSB     5
`define MC_WORD_LSB     0

`define MC_FIFO_DEPTH   4
`define MC_RESET_DEPTH  3   // stages between tag done and core reset release

`endif

// File: mc_link_pkg.sv
//*********************************************************************
// host link types: data word, word address, request regions,
// queued request and response records
//*********************************************************************
`default_nettype none

`include "mc_consts.svh"

package mc_link_pkg;

  typedef logic [`MC_DATA_W-1:0] word_t;
  typedef logic [`MC_ADDR_W-1:0] addr_t;

  // top two address bits pick the request kind
  typedef enum logic [1:0] {
    REG_DMEM    = 2'd0,
    REG_AMO     = 2'd1,
    REG_MAILBOX = 2'd2,
    REG_CTR     = 2'd3
  } region_e;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
  } link_req_s;

  typedef struct packed {
    logic  is_ctr;   // set for global counter reads
    word_t data;
  } link_rsp_s;

endpackage

`default_nettype wire

// File: mc_pod_pkg.sv
//*********************************************************************
// pod types: tile index, memory word index, mailbox stat record
//*********************************************************************
`default_nettype none

`include "mc_consts.svh"

package mc_pod_pkg;

  typedef logic [$clog2(`MC_NUM_TILES)-1:0]  tile_id_t;
  typedef logic [$clog2(`MC_DMEM_WORDS)-1:0] dmem_idx_t;

  // one print-stat event from the mailbox
  typedef struct packed {
    mc_link_pkg::word_t tag;
  } stat_s;

endpackage

`default_nettype wire

// File: mc_link_if.sv
//*********************************************************************
// wishbone classic link between host controller and one tile memory
//*********************************************************************
`default_nettype none

interface mc_link_if;
  import mc_link_pkg::*;
  import mc_pod_pkg::*;

  logic      cyc;
  logic      stb;
  logic      we;
  logic      amo;     // atomic add, old value returned
  dmem_idx_t adr;
  word_t     dat_w;
  word_t     dat_r;
  logic      ack;

  modport master (
    output cyc, stb, we, amo, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, amo, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// File: mc_link_fifo.sv
//*********************************************************************
// synchronous circular-buffer fifo, payload type given as parameter,
// valid/ready on both sides
//*********************************************************************
`default_nettype none

module mc_link_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_v_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_v_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             push, pop;

  assign push_ready_o = (count_q != cnt_w'(depth));
  assign pop_v_o      = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push         = push_v_i && push_ready_o;
  assign pop          = pop_v_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

// File: mc_tile_mem.sv
//*********************************************************************
// tile data memory: load, store and atomic add over the link,
// plus a clear port used during tag programming
//*********************************************************************
`default_nettype none

`include "mc_consts.svh"

module mc_tile_mem (
  input  logic                  clk_i,
  input  logic                  reset_i,
  mc_link_if.slave              link,
  input  logic                  clr_v_i,
  input  mc_pod_pkg::dmem_idx_t clr_idx_i
);
  import mc_link_pkg::*;

  word_t mem_q [`MC_DMEM_WORDS];
  word_t dat_q;
  logic  ack_q;
  logic  access;
  word_t old_word;

  // one access per stb, the clear port wins
  assign access   = link.cyc && link.stb && !ack_q && !clr_v_i;
  assign old_word = mem_q[link.adr];

  assign link.ack   = ack_q;
  assign link.dat_r = dat_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (clr_v_i) begin
      mem_q[clr_idx_i] <= '0;
    end else if (access) begin
      if (link.amo) begin
        mem_q[link.adr] <= old_word + link.dat_w;
      end else if (link.we) begin
        mem_q[link.adr] <= link.dat_w;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) dat_q <= old_word;   // old value for loads and amo
  end

endmodule

`default_nettype wire

// File: mc_host_ctrl.sv
//*********************************************************************
// host controller: memory clear, core reset chain, host ack,
// request decode, tile access, cycle counter, mailbox, responses
//*********************************************************************
`default_nettype none

`include "mc_consts.svh"

module mc_host_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  mc_link_pkg::addr_t     wb_adr_i,
  input  mc_link_pkg::word_t     wb_dat_i,
  output logic                   wb_ack_o,
  output logic                   req_push_v_o,
  output mc_link_pkg::link_req_s req_push_data_o,
  input  logic                   req_push_ready_i,
  input  logic                   req_pop_v_i,
  input  mc_link_pkg::link_req_s req_pop_data_i,
  output logic                   req_pop_ready_o,
  output logic                   rsp_push_v_o,
  output mc_link_pkg::link_rsp_s rsp_push_data_o,
  input  logic                   rsp_push_ready_i,
  mc_link_if.master              tile [`MC_NUM_TILES],
  output logic                   clr_v_o,
  output mc_pod_pkg::dmem_idx_t  clr_idx_o,
  output logic                   print_stat_v_o,
  output mc_link_pkg::word_t     print_stat_tag_o,
  output logic                   core_reset_o
);
  import mc_link_pkg::*;
  import mc_pod_pkg::*;

  typedef enum logic [2:0] {S_CLEAR, S_CHAIN, S_IDLE, S_ACCESS, S_RSP} state_e;

  state_e                     state_q;
  dmem_idx_t                  clr_idx_q;
  logic [`MC_RESET_DEPTH-1:0] chain_q;
  logic                       ack_q, stb_q, stat_v_q, pop_fire;
  word_t                      ctr_q;
  link_req_s                  req_q;
  link_rsp_s                  rsp_q;
  stat_s                      stat_q;
  region_e                    pop_region, req_region;
  tile_id_t                   req_tile;
  logic [`MC_NUM_TILES-1:0]   ack_vec;
  word_t                      dat_vec [`MC_NUM_TILES];

  assign pop_region = region_e'(req_pop_data_i.addr[`MC_REGION_MSB:`MC_REGION_LSB]);
  assign req_region = region_e'(req_q.addr[`MC_REGION_MSB:`MC_REGION_LSB]);
  assign req_tile   = tile_id_t'(req_q.addr[`MC_TILE_MSB:`MC_TILE_LSB]);
  assign pop_fire   = req_pop_ready_o && req_pop_v_i;

  assign core_reset_o     = chain_q[`MC_RESET_DEPTH-1];
  assign wb_ack_o         = ack_q;
  assign req_push_v_o     = ack_q;   // host still holds adr/dat during ack
  assign req_push_data_o  = '{we: wb_we_i, addr: wb_adr_i, data: wb_dat_i};
  assign req_pop_ready_o  = (state_q == S_IDLE);
  assign rsp_push_v_o     = (state_q == S_RSP);
  assign rsp_push_data_o  = rsp_q;
  assign clr_v_o          = (state_q == S_CLEAR);
  assign clr_idx_o        = clr_idx_q;
  assign print_stat_v_o   = stat_v_q;
  assign print_stat_tag_o = stat_q.tag;

  for (genvar i = 0; i < `MC_NUM_TILES; i++) begin : g_tile
    assign tile[i].cyc   = stb_q && (req_tile == tile_id_t'(i));
    assign tile[i].stb   = stb_q && (req_tile == tile_id_t'(i));
    assign tile[i].we    = req_q.we;
    assign tile[i].amo   = (req_region == REG_AMO);
    assign tile[i].adr   = req_q.addr[`MC_WORD_MSB:`MC_WORD_LSB];
    assign tile[i].dat_w = req_q.data;
    assign ack_vec[i]    = tile[i].ack;
    assign dat_vec[i]    = tile[i].dat_r;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= S_CLEAR;
      clr_idx_q <= '0;
      chain_q   <= '1;
      ack_q     <= 1'b0;
      stb_q     <= 1'b0;
      stat_v_q  <= 1'b0;
      ctr_q     <= '0;
    end else begin
      chain_q  <= {chain_q[`MC_RESET_DEPTH-2:0], state_q == S_CLEAR};
      ack_q    <= wb_cyc_i && wb_stb_i && !ack_q && !core_reset_o && req_push_ready_i;
      ctr_q    <= core_reset_o ? '0 : ctr_q + 1'b1;
      stat_v_q <= 1'b0;
      case (state_q)
        S_CLEAR: begin
          clr_idx_q <= clr_idx_q + 1'b1;
          if (clr_idx_q == dmem_idx_t'(`MC_DMEM_WORDS - 1)) state_q <= S_CHAIN;
        end
        S_CHAIN: if (!core_reset_o) state_q <= S_IDLE;
        S_IDLE: begin
          if (pop_fire) begin
            case (pop_region)
              REG_DMEM, REG_AMO: begin
                stb_q   <= 1'b1;
                state_q <= S_ACCESS;
              end
              REG_MAILBOX: stat_v_q <= req_pop_data_i.we;
              default:     state_q  <= S_RSP;   // counter read
            endcase
          end
        end
        S_ACCESS: begin
          if (ack_vec[req_tile]) begin
            stb_q   <= 1'b0;
            state_q <= (!req_q.we || req_region == REG_AMO) ? S_RSP : S_IDLE;
          end
        end
        S_RSP:   if (rsp_push_ready_i) state_q <= S_IDLE;
        default: state_q <= S_CLEAR;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      req_q  <= req_pop_data_i;
      rsp_q  <= '{is_ctr: 1'b1, data: ctr_q};   // counter snapshot
      stat_q <= '{tag: req_pop_data_i.data};
    end
    if (state_q == S_ACCESS && ack_vec[req_tile]) begin
      rsp_q <= '{is_ctr: 1'b0, data: dat_vec[req_tile]};
    end
  end

endmodule

`default_nettype wire

// File: mc_pod.sv
//*********************************************************************
// pod top: host controller, request and response fifos, tile row
//*********************************************************************
`default_nettype none

`include "mc_consts.svh"

module mc_pod (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  mc_link_pkg::addr_t wb_adr_i,
  input  mc_link_pkg::word_t wb_dat_i,
  output logic               wb_ack_o,
  output logic               rsp_v_o,
  output mc_link_pkg::word_t rsp_data_o,
  input  logic               rsp_ready_i,
  output logic               print_stat_v_o,
  output mc_link_pkg::word_t print_stat_tag_o,
  output logic               core_reset_o
);
  import mc_link_pkg::*;
  import mc_pod_pkg::*;

  logic      req_push_v, req_push_ready, req_pop_v, req_pop_ready;
  link_req_s req_push_data, req_pop_data;
  logic      rsp_push_v, rsp_push_ready;
  link_rsp_s rsp_push_data, rsp_pop_data;
  logic      clr_v;
  dmem_idx_t clr_idx;

  mc_link_if link_if [`MC_NUM_TILES] ();

  mc_host_ctrl u_ctrl (
    .clk_i, .reset_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_ack_o,
    .req_push_v_o(req_push_v), .req_push_data_o(req_push_data),
    .req_push_ready_i(req_push_ready),
    .req_pop_v_i(req_pop_v), .req_pop_data_i(req_pop_data),
    .req_pop_ready_o(req_pop_ready),
    .rsp_push_v_o(rsp_push_v), .rsp_push_data_o(rsp_push_data),
    .rsp_push_ready_i(rsp_push_ready),
    .tile(link_if),
    .clr_v_o(clr_v), .clr_idx_o(clr_idx),
    .print_stat_v_o, .print_stat_tag_o, .core_reset_o
  );

  mc_link_fifo #(.payload_t(link_req_s), .depth(`MC_FIFO_DEPTH)) u_req_fifo (
    .clk_i, .reset_i,
    .push_v_i(req_push_v), .push_data_i(req_push_data), .push_ready_o(req_push_ready),
    .pop_v_o(req_pop_v), .pop_data_o(req_pop_data), .pop_ready_i(req_pop_ready)
  );

  mc_link_fifo #(.payload_t(link_rsp_s), .depth(`MC_FIFO_DEPTH)) u_rsp_fifo (
    .clk_i, .reset_i,
    .push_v_i(rsp_push_v), .push_data_i(rsp_push_data), .push_ready_o(rsp_push_ready),
    .pop_v_o(rsp_v_o), .pop_data_o(rsp_pop_data), .pop_ready_i(rsp_ready_i)
  );

  assign rsp_data_o = rsp_pop_data.data;

  for (genvar i = 0; i < `MC_NUM_TILES; i++) begin : g_tile
    mc_tile_mem u_tile (
      .clk_i, .reset_i,
      .link(link_if[i]),
      .clr_v_i(clr_v), .clr_idx_i(clr_idx)   // all tiles clear in parallel
    );
  end

endmodule

`default_nettype wire

// File: mc_pod_props.sv
//*********************************************************************
// concurrent protocol checks for the pod, bound into mc_pod
//*********************************************************************
`default_nettype none

module mc_pod_props (
  input logic               clk_i,
  input logic               reset_i,
  input logic               wb_cyc_i,
  input logic               wb_stb_i,
  input logic               wb_ack_o,
  input logic               rsp_v_o,
  input mc_link_pkg::word_t rsp_data_o,
  input logic               rsp_ready_i,
  input logic               print_stat_v_o,
  input logic               core_reset_o
);
  timeunit 1ns;
  timeprecision 1ns;

  int fail_cnt = 0;   // read by the testbench

  // ack only inside a held cyc/stb, the request is pushed from the bus
  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i)))
    else begin
      fail_cnt++;
      $error("wb_ack_o without cyc and stb held across the ack cycle");
    end

  // response held while the host is not ready
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (rsp_v_o && !rsp_ready_i) |=> (rsp_v_o && $stable(rsp_data_o)))
    else begin
      fail_cnt++;
      $error("rsp_data_o changed or rsp_v_o dropped before the handshake");
    end

  a_quiet_in_reset: assert property (@(posedge clk_i) disable iff (reset_i)
    core_reset_o |-> (!wb_ack_o && !print_stat_v_o))
    else begin
      fail_cnt++;
      $error("ack or stat strobe while core_reset_o is high");
    end

endmodule

bind mc_pod mc_pod_props u_props (.*);

`default_nettype wire

// File: tb_mc_pod.sv
//*********************************************************************
// pod testbench: clock, reset, host stimulus, reference model,
// compare process and timeout
//*********************************************************************
`default_nettype none

`include "mc_consts.svh"

module tb_mc_pod;
  timeunit 1ns;
  timeprecision 1ns;
  import mc_link_pkg::*;
  import mc_pod_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 10;
  localparam int RESET_CYCLES = 5;
  localparam int ACK_WAIT     = 30;
  localparam int N_BP         = 12;
  localparam int N_REQ        = 16 + 40 + 12 + 5 + N_BP;
  localparam int MAX_CYCLES   = RESET_CYCLES + `MC_DMEM_WORDS + `MC_RESET_DEPTH + 20 * N_REQ;
  localparam logic [1:0] K_RSP = 2'd0, K_CTR = 2'd1, K_STAT = 2'd2;

  typedef struct packed {
    logic [1:0] kind;
    word_t      data;
  } exp_s;

  logic  clk_i, reset_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  addr_t wb_adr_i;
  word_t wb_dat_i, rsp_data_o, print_stat_tag_o;
  logic  rsp_v_o, rsp_ready_i, print_stat_v_o, core_reset_o;

  word_t model_mem [`MC_NUM_TILES][`MC_DMEM_WORDS];
  exp_s  exp_q [$];
  word_t last_ctr;
  int    seed;
  int    cycle_cnt;

  mc_pod u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(input word_t exp, input word_t act);
    if (exp !== act)
      abort_run($sformatf("[ERROR] t=%0t rsp_data_o expected %h got %h", $time, exp, act));
  endtask

  task automatic check_stat(input stat_s exp, input stat_s act);
    if (exp !== act)
      abort_run($sformatf("[ERROR] t=%0t print_stat_tag_o expected %h got %h",
                          $time, exp.tag, act.tag));
  endtask

  task automatic check_ctr(input word_t act);
    if (act <= last_ctr)
      abort_run($sformatf("[ERROR] t=%0t rsp_data_o counter expected above %h got %h",
                          $time, last_ctr, act));
    else
      last_ctr = act;
  endtask

  function automatic addr_t make_addr(input region_e region, input tile_id_t tile,
                                      input dmem_idx_t idx);
    addr_t a;
    a = '0;
    a[`MC_REGION_MSB:`MC_REGION_LSB] = region;
    a[`MC_TILE_MSB:`MC_TILE_LSB]     = tile;
    a[`MC_WORD_MSB:`MC_WORD_LSB]     = idx;
    return a;
  endfunction

  // model update for one acked request, returns what the pod should answer
  function automatic link_rsp_s ref_access(input link_req_s req);
    region_e   region;
    tile_id_t  t;
    dmem_idx_t w;
    word_t     old;
    link_rsp_s rsp;
    region = region_e'(req.addr[`MC_REGION_MSB:`MC_REGION_LSB]);
    t      = req.addr[`MC_TILE_MSB:`MC_TILE_LSB];
    w      = req.addr[`MC_WORD_MSB:`MC_WORD_LSB];
    old    = model_mem[t][w];
    rsp    = '{is_ctr: 1'b0, data: old};
    case (region)
      REG_DMEM:    if (req.we) model_mem[t][w] = req.data;
      REG_AMO:     model_mem[t][w] = old + req.data;
      REG_MAILBOX: rsp.data = req.data;   // tag for the stat strobe
      default:     rsp.is_ctr = 1'b1;
    endcase
    return rsp;
  endfunction

  task automatic enqueue_expected(input link_req_s req);
    link_rsp_s rsp;
    region_e   region;
    exp_s      e;
    rsp    = ref_access(req);
    region = region_e'(req.addr[`MC_REGION_MSB:`MC_REGION_LSB]);
    e.data = rsp.data;
    if (rsp.is_ctr) begin
      e.kind = K_CTR;
      exp_q.push_back(e);
    end else if (region == REG_MAILBOX) begin
      e.kind = K_STAT;
      exp_q.push_back(e);
    end else if (region == REG_AMO || !req.we) begin
      e.kind = K_RSP;
      exp_q.push_back(e);
    end
  endtask

  // called and returns at the drive point
  task automatic host_try(input logic we, input addr_t adr, input word_t dat,
                          input int max_wait, output bit acked);
    int n;
    n     = 0;
    acked = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    while (!acked && n < max_wait) begin
      @(posedge clk_i);
      #1;
      n++;
      acked = wb_ack_o;
    end
    if (acked) begin
      enqueue_expected('{we: we, addr: adr, data: dat});
      @(posedge clk_i);   // request taken on this edge
      #DRIVE_DLY;
    end else begin
      #(DRIVE_DLY - 1);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic host_req(input logic we, input addr_t adr, input word_t dat);
    bit ok;
    host_try(we, adr, dat, ACK_WAIT, ok);
    if (!ok) abort_run($sformatf("no wb_ack_o within %0d cycles for address %h", ACK_WAIT, adr));
  endtask

  task automatic wait_drain();
    do @(posedge clk_i); while (exp_q.size() != 0);
    #DRIVE_DLY;
  endtask

  task automatic check_next(input logic [1:0] seen, input word_t value);
    exp_s  e;
    stat_s es, as;
    if (exp_q.size() == 0) begin
      abort_run("the pod answered with no request outstanding");
    end else begin
      e = exp_q.pop_front();
      if (seen == K_STAT && e.kind != K_STAT) begin
        abort_run("print_stat_v_o pulsed where a read response was expected");
      end else if (seen != K_STAT && e.kind == K_STAT) begin
        abort_run("a read response arrived where a mailbox stat was expected");
      end else if (e.kind == K_CTR) begin
        check_ctr(value);
      end else if (e.kind == K_STAT) begin
        es.tag = e.data;
        as.tag = value;
        check_stat(es, as);
      end else begin
        check_rsp(e.data, value);
      end
    end
  endtask

  // mid-cycle sampling, handshakes complete at the next rising edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (u_dut.u_props.fail_cnt != 0) abort_run("an assertion in mc_pod_props failed");
      if (rsp_v_o && rsp_ready_i) check_next(K_RSP, rsp_data_o);
      if (print_stat_v_o) check_next(K_STAT, print_stat_tag_o);
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
  end

  initial begin
    int        n_hold;
    int        n_acked;
    bit        ok;
    tile_id_t  t;
    dmem_idx_t w;
    word_t     v;
    seed        = 54767;
    last_ctr    = '0;
    reset_i     = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    rsp_ready_i = 1'b1;
    foreach (model_mem[i, j]) model_mem[i][j] = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;

    // stb held through tag programming must not be acked
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = make_addr(REG_MAILBOX, '0, '0);
    wb_dat_i = 32'h0000_00a5;
    n_hold   = 0;
    do begin
      @(posedge clk_i);
      #1;
      n_hold++;
      if (wb_ack_o) abort_run("wb_ack_o rose while core_reset_o was high");
    end while (core_reset_o);
    if (n_hold != `MC_DMEM_WORDS + `MC_RESET_DEPTH)
      abort_run($sformatf("[ERROR] t=%0t core_reset_o high cycles expected %0d got %0d",
                          $time, `MC_DMEM_WORDS + `MC_RESET_DEPTH, n_hold));
    #(DRIVE_DLY - 1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;

    for (int i = 0; i < `MC_NUM_TILES; i++) begin   // cleared memories read zero
      host_req(1'b0, make_addr(REG_DMEM, tile_id_t'(i), '0), '0);
      host_req(1'b0, make_addr(REG_DMEM, tile_id_t'(i), '1), '0);
      repeat (2) host_req(1'b0, make_addr(REG_DMEM, tile_id_t'(i), dmem_idx_t'($random(seed))), '0);
    end

    repeat (40) begin
      t = tile_id_t'($random(seed));
      w = dmem_idx_t'($random(seed)) & 6'd7;   // small window so loads hit stores
      if ($random(seed) & 1) host_req(1'b1, make_addr(REG_DMEM, t, w), $random(seed));
      else host_req(1'b0, make_addr(REG_DMEM, t, w), '0);
    end

    for (int i = 0; i < `MC_NUM_TILES; i++) begin
      w = dmem_idx_t'($random(seed));
      v = $random(seed);
      host_req(1'b1, make_addr(REG_DMEM, tile_id_t'(i), w), v);
      host_req(1'b1, make_addr(REG_AMO, tile_id_t'(i), w), $random(seed));
      host_req(1'b0, make_addr(REG_DMEM, tile_id_t'(i), w), '0);
    end

    host_req(1'b1, make_addr(REG_MAILBOX, '0, '0), $random(seed));
    host_req(1'b0, make_addr(REG_CTR, '0, '0), '0);
    host_req(1'b0, make_addr(REG_DMEM, 2'd1, '0), '0);
    host_req(1'b1, make_addr(REG_MAILBOX, '0, '0), $random(seed));
    host_req(1'b0, make_addr(REG_CTR, '0, '0), '0);
    wait_drain();

    // back-pressure: fill both fifos with ready low
    rsp_ready_i = 1'b0;
    n_acked     = 0;
    ok          = 1'b1;
    while (ok && n_acked < N_BP) begin
      t = tile_id_t'($random(seed));
      w = dmem_idx_t'($random(seed)) & 6'd7;
      host_try(1'b0, make_addr(REG_DMEM, t, w), '0, ACK_WAIT, ok);
      if (ok) n_acked++;
    end
    if (ok)
      abort_run("wb_ack_o never stopped while rsp_ready_i was held low");
    if (n_acked < 2 * `MC_FIFO_DEPTH)
      abort_run($sformatf("acks stopped after only %0d requests with rsp_ready_i low", n_acked));
    rsp_ready_i = 1'b1;
    repeat (N_BP - n_acked) begin
      t = tile_id_t'($random(seed));
      host_req(1'b0, make_addr(REG_DMEM, t, dmem_idx_t'($random(seed)) & 6'd7), '0);
    end
    wait_drain();

    if (u_dut.u_props.fail_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("assertion failures reported by mc_pod_props");
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
mc_link_pkg.sv
mc_pod_pkg.sv
mc_link_if.sv
mc_link_fifo.sv
mc_tile_mem.sv
mc_host_ctrl.sv
mc_pod.sv
mc_pod_props.sv
tb_mc_pod.sv

// File: Bender.yml
package:
  name: mc_pod

export_include_dirs:
  - .

sources:
  - files:
      - mc_link_pkg.sv
      - mc_pod_pkg.sv
      - mc_link_if.sv
      - mc_link_fifo.sv
      - mc_tile_mem.sv
      - mc_host_ctrl.sv
      - mc_pod.sv
  - target: test
    files:
      - mc_pod_props.sv
      - tb_mc_pod.sv
